// ==== rvCore_consts.svh ====
`ifndef RVCORE_CONSTS_SVH
`define RVCORE_CONSTS_SVH

// datapath width, RV64
`define XLEN 64

`define ALUOP_WIDTH 5   // enough for every aluOpT member

`define RESET_PC 64'h0

// architectural registers x0..x31
`define NUM_REGS 32

`endif

// ==== rvIsaPkg.sv ====
`include "rvCore_consts.svh"

package rvIsaPkg;

    typedef logic [31:0]        instrT;
    typedef logic [`XLEN-1:0]   wordT;
    typedef logic [4:0]         regIdxT;
    typedef logic [5:0]         shamtT;
    typedef logic [6:0]         opcodeT;

    // major opcodes of the supported subset
    localparam opcodeT opR      = 7'b0110011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opR32    = 7'b0111011;
    localparam opcodeT opImm32  = 7'b0011011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;

    typedef enum logic [`ALUOP_WIDTH-1:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluAddW,
        aluSubW,
        aluSllW,
        aluSrlW,
        aluSraW,
        aluPassB,   // lui
        aluLink     // return address
    } aluOpT;

    // rs1 vs rs2 compare results
    typedef logic [2:0] cmpFlagsT;
    localparam int cmpEq  = 0;
    localparam int cmpLt  = 1;   // signed
    localparam int cmpLtu = 2;   // unsigned

endpackage

// ==== rvCtrlPkg.sv ====
package rvCtrlPkg;

    typedef enum logic {
        aRs1,
        aPc
    } aSelT;

    typedef enum logic [1:0] {
        bRs2,
        bImm,
        bShamt,
        bPc
    } bSelT;

    // immediate format, width before sign extension noted
    typedef enum logic [2:0] {
        immNone,
        immU,       // 32
        immB,       // 13
        immJ,       // 21
        immI,       // 12
        immS        // 12
    } immSelT;

    typedef enum logic [1:0] {
        pcSeq,
        pcTarget,   // branch or jal
        pcJalr
    } pcSelT;

    typedef enum logic {
        wbAlu,
        wbLoad
    } wbSelT;

endpackage

// ==== ctrlIf.sv ====
`timescale 1ns/10ps

interface ctrlIf import rvIsaPkg::*, rvCtrlPkg::*; ();

    aluOpT  aluOp;
    aSelT   aSel;
    bSelT   bSel;
    immSelT immSel;
    pcSelT  pcSel;
    wbSelT  wbSel;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    shamtT  shamt;

    // decoder side
    modport dec (
        output aluOp, aSel, bSel, immSel, pcSel, wbSel,
        output regWrite, memRead, memWrite,
        output rd, rs1, rs2, shamt
    );

    // datapath blocks, each picks its own fields
    modport dp (
        input aluOp, aSel, bSel, immSel, pcSel, wbSel,
        input regWrite, memRead, memWrite,
        input rd, rs1, rs2, shamt
    );

endinterface

// ==== decoder.sv ====
`timescale 1ns/10ps

module decoder import rvIsaPkg::*, rvCtrlPkg::*; (
    input  instrT    instr,
    input  cmpFlagsT cmpFlags,
    ctrlIf.dec       ctrl
);

    opcodeT     op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    logic       f7Zero;
    logic       f7Alt;
    logic       add, sub, andR, orR, xorR, slt, sltu, sll, srl, sra;
    logic       addi, andi, ori, xori, slti, sltiu, slli, srli, srai;
    logic       addw, subw, sllw, srlw, sraw, addiw, slliw, srliw, sraiw;
    logic       lui, auipc, jal, jalr, ld, sd;
    logic       beq, bne, blt, bge, bltu, bgeu;
    logic       immArith;
    logic       shiftImm;
    logic       branch;
    logic       takeBranch;

    assign op     = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];
    assign f7Zero = (funct7 == 7'b0000000);
    assign f7Alt  = (funct7 == 7'b0100000);

    assign add  = (op == opR) && (funct3 == 3'b000) && f7Zero;
    assign sub  = (op == opR) && (funct3 == 3'b000) && f7Alt;
    assign sll  = (op == opR) && (funct3 == 3'b001) && f7Zero;
    assign slt  = (op == opR) && (funct3 == 3'b010) && f7Zero;
    assign sltu = (op == opR) && (funct3 == 3'b011) && f7Zero;
    assign xorR = (op == opR) && (funct3 == 3'b100) && f7Zero;
    assign srl  = (op == opR) && (funct3 == 3'b101) && f7Zero;
    assign sra  = (op == opR) && (funct3 == 3'b101) && f7Alt;
    assign orR  = (op == opR) && (funct3 == 3'b110) && f7Zero;
    assign andR = (op == opR) && (funct3 == 3'b111) && f7Zero;

    assign addi  = (op == opImm) && (funct3 == 3'b000);
    assign slli  = (op == opImm) && (funct3 == 3'b001) && (funct6 == 6'b000000);
    assign slti  = (op == opImm) && (funct3 == 3'b010);
    assign sltiu = (op == opImm) && (funct3 == 3'b011);
    assign xori  = (op == opImm) && (funct3 == 3'b100);
    assign srli  = (op == opImm) && (funct3 == 3'b101) && (funct6 == 6'b000000);
    assign srai  = (op == opImm) && (funct3 == 3'b101) && (funct6 == 6'b010000);
    assign ori   = (op == opImm) && (funct3 == 3'b110);
    assign andi  = (op == opImm) && (funct3 == 3'b111);

    // word forms need shamt[5] clear
    assign addw  = (op == opR32) && (funct3 == 3'b000) && f7Zero;
    assign subw  = (op == opR32) && (funct3 == 3'b000) && f7Alt;
    assign sllw  = (op == opR32) && (funct3 == 3'b001) && f7Zero;
    assign srlw  = (op == opR32) && (funct3 == 3'b101) && f7Zero;
    assign sraw  = (op == opR32) && (funct3 == 3'b101) && f7Alt;
    assign addiw = (op == opImm32) && (funct3 == 3'b000);
    assign slliw = (op == opImm32) && (funct3 == 3'b001) && f7Zero;
    assign srliw = (op == opImm32) && (funct3 == 3'b101) && f7Zero;
    assign sraiw = (op == opImm32) && (funct3 == 3'b101) && f7Alt;

    assign lui   = (op == opLui);
    assign auipc = (op == opAuipc);
    assign jal   = (op == opJal);
    assign jalr  = (op == opJalr) && (funct3 == 3'b000);
    assign ld    = (op == opLoad) && (funct3 == 3'b011);
    assign sd    = (op == opStore) && (funct3 == 3'b011);

    assign beq  = (op == opBranch) && (funct3 == 3'b000);
    assign bne  = (op == opBranch) && (funct3 == 3'b001);
    assign blt  = (op == opBranch) && (funct3 == 3'b100);
    assign bge  = (op == opBranch) && (funct3 == 3'b101);
    assign bltu = (op == opBranch) && (funct3 == 3'b110);
    assign bgeu = (op == opBranch) && (funct3 == 3'b111);

    assign immArith = addi | slti | sltiu | xori | ori | andi | addiw;
    assign shiftImm = slli | srli | srai | slliw | srliw | sraiw;
    assign branch   = beq | bne | blt | bge | bltu | bgeu;
    assign takeBranch = (beq  &  cmpFlags[cmpEq])  | (bne  & ~cmpFlags[cmpEq])
                      | (blt  &  cmpFlags[cmpLt])  | (bge  & ~cmpFlags[cmpLt])
                      | (bltu &  cmpFlags[cmpLtu]) | (bgeu & ~cmpFlags[cmpLtu]);

    // mul/div/rem and anything unknown fall through with no write
    assign ctrl.regWrite = add | sub | andR | orR | xorR | slt | sltu | sll | srl | sra
                         | immArith | shiftImm | addw | subw | sllw | srlw | sraw
                         | lui | auipc | jal | jalr | ld;
    assign ctrl.memRead  = ld;
    assign ctrl.memWrite = sd;
    assign ctrl.wbSel    = ld ? wbLoad : wbAlu;
    assign ctrl.aSel     = auipc ? aPc : aRs1;

    assign ctrl.rd    = instr[11:7];
    assign ctrl.rs1   = instr[19:15];
    assign ctrl.rs2   = instr[24:20];
    assign ctrl.shamt = instr[25:20];

    always_comb begin
        if (sub)                ctrl.aluOp = aluSub;
        else if (andR | andi)   ctrl.aluOp = aluAnd;
        else if (orR | ori)     ctrl.aluOp = aluOr;
        else if (xorR | xori)   ctrl.aluOp = aluXor;
        else if (slt | slti)    ctrl.aluOp = aluSlt;
        else if (sltu | sltiu)  ctrl.aluOp = aluSltu;
        else if (sll | slli)    ctrl.aluOp = aluSll;
        else if (srl | srli)    ctrl.aluOp = aluSrl;
        else if (sra | srai)    ctrl.aluOp = aluSra;
        else if (addw | addiw)  ctrl.aluOp = aluAddW;
        else if (subw)          ctrl.aluOp = aluSubW;
        else if (sllw | slliw)  ctrl.aluOp = aluSllW;
        else if (srlw | srliw)  ctrl.aluOp = aluSrlW;
        else if (sraw | sraiw)  ctrl.aluOp = aluSraW;
        else if (lui)           ctrl.aluOp = aluPassB;
        else if (jal | jalr)    ctrl.aluOp = aluLink;
        else                    ctrl.aluOp = aluAdd;  // add, addi, auipc, address calc
    end

    always_comb begin
        if (shiftImm)                               ctrl.bSel = bShamt;
        else if (immArith | lui | auipc | ld | sd)  ctrl.bSel = bImm;
        else if (jal | jalr)                        ctrl.bSel = bPc;
        else                                        ctrl.bSel = bRs2;
    end

    always_comb begin
        if (lui | auipc)                ctrl.immSel = immU;
        else if (branch)                ctrl.immSel = immB;
        else if (jal)                   ctrl.immSel = immJ;
        else if (immArith | jalr | ld)  ctrl.immSel = immI;
        else if (sd)                    ctrl.immSel = immS;
        else                            ctrl.immSel = immNone;
    end

    always_comb begin
        if (jal | takeBranch)   ctrl.pcSel = pcTarget;
        else if (jalr)          ctrl.pcSel = pcJalr;
        else                    ctrl.pcSel = pcSeq;
    end

    // at most one row of the decode table may match, so ld and sd never overlap
    decodeOneHot: assert final ($onehot0({add, sub, andR, orR, xorR, slt, sltu, sll, srl, sra,
                                          addi, andi, ori, xori, slti, sltiu, slli, srli, srai,
                                          addw, subw, sllw, srlw, sraw,
                                          addiw, slliw, srliw, sraiw,
                                          lui, auipc, jal, jalr, ld, sd,
                                          beq, bne, blt, bge, bltu, bgeu}))
        else $error("decoder: more than one instruction decoded");

endmodule

// ==== immGen.sv ====
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module immGen import rvIsaPkg::*, rvCtrlPkg::*; (
    ctrlIf.dp     ctrl,
    input  instrT instr,
    output wordT  imm
);

    logic signBit;

    assign signBit = instr[31];  // every format keeps its sign here

    always_comb begin
        case (ctrl.immSel)
            immU: begin
                imm = {{(`XLEN-32){signBit}}, instr[31:12], 12'b0};
            end
            immB: begin
                imm = {{(`XLEN-12){signBit}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{(`XLEN-20){signBit}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            immI: begin
                imm = {{(`XLEN-12){signBit}}, instr[31:20]};
            end
            immS: begin
                imm = {{(`XLEN-12){signBit}}, instr[31:25], instr[11:7]};
            end
            default: begin
                imm = '0;   // immNone
            end
        endcase
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module regFile import rvIsaPkg::*; (
    input  logic clk,
    input  logic reset,
    ctrlIf.dp    ctrl,
    input  wordT wrData,
    output wordT rs1Data,
    output wordT rs2Data
);

    wordT regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (ctrl.rd != '0)) begin
            regs[ctrl.rd] <= wrData;
        end
    end

    // x0 is hardwired
    assign rs1Data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2Data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module alu import rvIsaPkg::*, rvCtrlPkg::*; (
    ctrlIf.dp        ctrl,
    input  wordT     rs1Data,
    input  wordT     rs2Data,
    input  wordT     imm,
    input  wordT     pc,
    output wordT     result,
    output cmpFlagsT cmpFlags
);

    wordT       opA;
    wordT       opB;
    shamtT      shamt;
    logic [4:0] shamtW;     // word shifts ignore bit 5

    function automatic wordT sextW(input logic [31:0] w);
        return {{(`XLEN-32){w[31]}}, w};
    endfunction

    assign opA = (ctrl.aSel == aPc) ? pc : rs1Data;

    always_comb begin
        case (ctrl.bSel)
            bImm:    opB = imm;
            bShamt:  opB = wordT'(ctrl.shamt);
            bPc:     opB = pc;
            default: opB = rs2Data;
        endcase
    end

    assign shamt  = opB[5:0];
    assign shamtW = opB[4:0];

    always_comb begin
        case (ctrl.aluOp)
            aluSub:   result = opA - opB;
            aluAnd:   result = opA & opB;
            aluOr:    result = opA | opB;
            aluXor:   result = opA ^ opB;
            aluSlt:   result = wordT'($signed(opA) < $signed(opB));
            aluSltu:  result = wordT'(opA < opB);
            aluSll:   result = opA << shamt;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $signed(opA) >>> shamt;
            aluAddW:  result = sextW(opA[31:0] + opB[31:0]);
            aluSubW:  result = sextW(opA[31:0] - opB[31:0]);
            aluSllW:  result = sextW(opA[31:0] << shamtW);
            aluSrlW:  result = sextW(opA[31:0] >> shamtW);
            aluSraW:  result = sextW($signed(opA[31:0]) >>> shamtW);
            aluPassB: result = opB;
            aluLink:  result = opB + 'd4;   // opB holds pc on jumps
            default:  result = opA + opB;
        endcase
    end

    // branch compares always look at the raw register values
    assign cmpFlags[cmpEq]  = (rs1Data == rs2Data);
    assign cmpFlags[cmpLt]  = ($signed(rs1Data) < $signed(rs2Data));
    assign cmpFlags[cmpLtu] = (rs1Data < rs2Data);

endmodule

// ==== pcUnit.sv ====
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module pcUnit import rvIsaPkg::*, rvCtrlPkg::*; (
    input  logic clk,
    input  logic reset,
    ctrlIf.dp    ctrl,
    input  wordT imm,
    input  wordT rs1Data,
    output wordT pc
);

    wordT pcNext;
    wordT jalrSum;

    assign jalrSum = rs1Data + imm;

    always_comb begin
        case (ctrl.pcSel)
            pcTarget: pcNext = pc + imm;
            pcJalr:   pcNext = {jalrSum[`XLEN-1:1], 1'b0};  // lsb dropped per ISA
            default:  pcNext = pc + 'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= wordT'(`RESET_PC);
        end else begin
            pc <= pcNext;
        end
    end

    // targets built from decoder, immGen and register data must stay word aligned
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pcUnit: misaligned pc %h", pc);

endmodule

// ==== rvCore.sv ====
`timescale 1ns/10ps

module rvCore import rvIsaPkg::*, rvCtrlPkg::*; (
    input  logic  clk,
    input  logic  reset,
    output wordT  pc,
    input  instrT instr,
    output wordT  dataAddr,
    output wordT  dataWrite,
    input  wordT  dataRead,
    output logic  memRead,
    output logic  memWrite
);

    wordT     imm;
    wordT     rs1Data;
    wordT     rs2Data;
    wordT     aluResult;
    wordT     wrData;
    cmpFlagsT cmpFlags;

    ctrlIf ctrl ();

    decoder decoder_i (
        .instr    (instr),
        .cmpFlags (cmpFlags),
        .ctrl     (ctrl.dec)
    );

    immGen immGen_i (
        .ctrl  (ctrl.dp),
        .instr (instr),
        .imm   (imm)
    );

    // writeback mux, load data or alu
    assign wrData = (ctrl.wbSel == wbLoad) ? dataRead : aluResult;

    regFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl.dp),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    alu alu_i (
        .ctrl     (ctrl.dp),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .imm      (imm),
        .pc       (pc),
        .result   (aluResult),
        .cmpFlags (cmpFlags)
    );

    pcUnit pcUnit_i (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl.dp),
        .imm     (imm),
        .rs1Data (rs1Data),
        .pc      (pc)
    );

    assign dataAddr  = aluResult;   // rs1 + offset for ld/sd
    assign dataWrite = rs2Data;
    assign memRead   = ctrl.memRead;
    assign memWrite  = ctrl.memWrite;

endmodule

// ==== rvCoreTbProg.svh ====
`ifndef RVCORETBPROG_SVH
`define RVCORETBPROG_SVH

function automatic instrT rType(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic instrT iType(input logic [11:0] imm, input logic [4:0] rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// sd only, funct3 fixed
function automatic instrT sType(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'h3, imm[4:0], 7'h23};
endfunction

function automatic instrT bType(input logic [12:0] off, input logic [4:0] rs1, rs2,
                                input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic instrT uType(input logic [19:0] imm, input logic [4:0] rd,
                                input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic instrT jType(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

// galois lfsr, one step per bit
function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[62:0], lfsr[0]};
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
endfunction

task automatic put(input instrT w);
    imem[progLen] = w;
    progLen++;
endtask

// lui rounds up when bit 11 is set, addiw then subtracts
function automatic logic [19:0] upper(input logic [31:0] w);
    return w[31:12] + {19'b0, w[11]};
endfunction

// 64-bit constant into rd, x31 is scratch
task automatic loadConst(input logic [4:0] rd, input logic [63:0] v);
    put(uType(upper(v[63:32]), rd, 7'h37));
    put(iType(v[43:32], rd, 3'h0, rd, 7'h1b));
    put(iType(12'd32, rd, 3'h1, rd, 7'h13));
    put(uType(upper(v[31:0]), 5'd31, 7'h37));
    put(iType(v[11:0], 5'd31, 3'h0, 5'd31, 7'h1b));
    put(iType(12'd32, 5'd31, 3'h1, 5'd31, 7'h13));
    put(iType(12'd32, 5'd31, 3'h5, 5'd31, 7'h13));  // drop sign copies
    put(rType(7'h00, 5'd31, rd, 3'h6, rd, 7'h33));
endtask

// group 0 R, 1 R32, 2 I, 3 I32
function automatic instrT randomAluOp(input logic [4:0] rd, rs1, rs2);
    logic [1:0]  group;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [6:0]  f7;
    group = 2'(randBits(2));
    f3    = 3'(randBits(3));
    alt   = 1'(randBits(1));
    imm   = 12'(randBits(12));
    if (group[0] && !(f3 inside {3'h0, 3'h1, 3'h5})) begin
        f3 = 3'h0;  // word forms only have add/sub and shifts
    end
    f7 = (alt && (f3 == 3'h0 || f3 == 3'h5)) ? 7'h20 : 7'h00;
    case (group)
        2'd0: return rType(f7, rs2, rs1, f3, rd, 7'h33);
        2'd1: return rType(f7, rs2, rs1, f3, rd, 7'h3b);
        2'd2: begin
            if (f3 == 3'h1 || f3 == 3'h5) begin
                imm = {f7[6:1], imm[5:0]};  // 6-bit shamt
            end
            return iType(imm, rs1, f3, rd, 7'h13);
        end
        default: begin
            if (f3 != 3'h0) begin
                imm = {f7, imm[4:0]};
            end
            return iType(imm, rs1, f3, rd, 7'h1b);
        end
    endcase
endfunction

task automatic buildProgram();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] d;
    logic [4:0]  rd;
    progLen = 0;
    put(iType(12'd1024, 5'd0, 3'h0, 5'd1, 7'h13));  // x1 is the store base
    for (int r = 2; r < 10; r++) begin
        loadConst(5'(r), randBits(64));
    end
    for (int k = 0; k < 40; k++) begin
        rd = (k % 8 == 7) ? 5'd0 : 5'(10 + k % 10);
        put(randomAluOp(rd, 5'(2 + randBits(3)), 5'(2 + randBits(3))));
        put(sType(12'(8 * k), rd, 5'd1));
    end
    // store, load back, store again, then x0 as a destination
    put(sType(12'd512, 5'd2, 5'd1));
    put(iType(12'd512, 5'd1, 3'h3, 5'd27, 7'h03));
    put(sType(12'd520, 5'd27, 5'd1));
    put(rType(7'h00, 5'd3, 5'd2, 3'h0, 5'd0, 7'h33));
    put(sType(12'd528, 5'd0, 5'd1));
    put(iType(12'd1016, 5'd1, 3'h3, 5'd28, 7'h03));  // untouched fill word
    put(sType(12'd544, 5'd28, 5'd1));
    for (int k = 0; k < 6; k++) begin
        for (int c = 0; c < 4; c++) begin
            a = randBits(64);
            d = randBits(8) + 64'd1;
            case (c)
                0: b = a;
                1: b = a + d;
                2: begin
                    b = a;
                    a = a + d;
                end
                default: b = a ^ {1'b1, 63'b0};  // signed and unsigned disagree
            endcase
            loadConst(5'd2, a);
            loadConst(5'd3, b);
            put(bType(13'd8, 5'd2, 5'd3, 3'((k < 2) ? k : k + 2)));
            put(iType(12'd1, 5'd21, 3'h0, 5'd21, 7'h13));  // skipped when taken
        end
    end
    put(jType(21'd12, 5'd22));
    put(iType(12'd1, 5'd21, 3'h0, 5'd21, 7'h13));
    put(iType(12'd2, 5'd21, 3'h0, 5'd21, 7'h13));
    put(sType(12'd552, 5'd22, 5'd1));
    put(uType(20'd0, 5'd23, 7'h17));
    put(iType(12'd13, 5'd23, 3'h0, 5'd24, 7'h67));  // odd offset, lands 12 past auipc
    put(iType(12'd3, 5'd21, 3'h0, 5'd21, 7'h13));
    put(sType(12'd560, 5'd24, 5'd1));
    for (int k = 0; k < 4; k++) begin
        put(uType(20'(randBits(20)), 5'd25, 7'h37));
        put(sType(12'(568 + 16 * k), 5'd25, 5'd1));
        put(uType(20'(randBits(20)), 5'd26, 7'h17));
        put(sType(12'(576 + 16 * k), 5'd26, 5'd1));
    end
    haltPc = wordT'(progLen) * 64'd4;
    put(jType(21'd0, 5'd0));  // parks here
endtask

`endif

// ==== rvCoreTb.sv ====
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module rvCoreTb import rvIsaPkg::*; ();

    localparam instrT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

    logic  clk;
    logic  reset;
    wordT  pc;
    instrT instr;
    wordT  dataAddr;
    wordT  dataWrite;
    wordT  dataRead;
    logic  memRead;
    logic  memWrite;

    instrT       imem [1024];
    wordT        dmem [256];
    int          progLen;
    wordT        haltPc;
    logic [31:0] lfsr;
    int          errors;
    int          cycles;
    int          limit;
    logic        finished;

    // reference model
    wordT  mPc;
    wordT  mRegs [32];
    wordT  mMem [256];
    instrT mInstr;
    wordT  mNextPc;
    wordT  mWrVal;
    wordT  mAddr;
    wordT  mData;
    logic  mWrEn;
    logic  mStore;
    logic  mLoad;

    `include "rvCoreTbProg.svh"

    rvCore dut_i (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataRead  (dataRead),
        .memRead   (memRead),
        .memWrite  (memWrite)
    );

    always #50 clk = ~clk;

    assign instr    = reset ? nopInstr : imem[pc[11:2]];
    assign dataRead = dmem[dataAddr[10:3]];

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[dataAddr[10:3]] <= dataWrite;
        end
    end

    function automatic wordT fillWord(input int idx);
        logic [31:0] addr;
        addr = 32'(idx) * 32'd8;
        return {addr * 32'h9e37_79b9, ~addr};
    endfunction

    function automatic wordT alu64(input logic [2:0] f3, input logic alt, input wordT x, y);
        case (f3)
            3'h0: return alt ? x - y : x + y;
            3'h1: return x << y[5:0];
            3'h2: return {63'b0, $signed(x) < $signed(y)};
            3'h3: return {63'b0, x < y};
            3'h4: return x ^ y;
            3'h5: begin
                if (alt) begin
                    return $signed(x) >>> y[5:0];
                end
                return x >> y[5:0];
            end
            3'h6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // word ops on the low half with the result sign extended
    function automatic wordT aluW(input logic [2:0] f3, input logic alt, input wordT x, y);
        logic [31:0] w;
        if (f3 == 3'h0) begin
            w = alt ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
        end else if (f3 == 3'h1) begin
            w = x[31:0] << y[4:0];
        end else if (alt) begin
            w = $signed(x[31:0]) >>> y[4:0];
        end else begin
            w = x[31:0] >> y[4:0];
        end
        return {{32{w[31]}}, w};
    endfunction

    always_comb begin : refModel
        wordT       a;
        wordT       b;
        wordT       immI;
        wordT       immS;
        wordT       immB;
        wordT       immU;
        wordT       immJ;
        logic [2:0] f3;
        logic       shiftAlt;
        logic       take;
        mInstr   = imem[mPc[11:2]];
        a        = mRegs[mInstr[19:15]];
        b        = mRegs[mInstr[24:20]];
        immI     = {{52{mInstr[31]}}, mInstr[31:20]};
        immS     = {{52{mInstr[31]}}, mInstr[31:25], mInstr[11:7]};
        immB     = {{52{mInstr[31]}}, mInstr[7], mInstr[30:25], mInstr[11:8], 1'b0};
        immU     = {{32{mInstr[31]}}, mInstr[31:12], 12'b0};
        immJ     = {{44{mInstr[31]}}, mInstr[19:12], mInstr[20], mInstr[30:21], 1'b0};
        f3       = mInstr[14:12];
        shiftAlt = (f3 == 3'h5) && mInstr[30];  // addi has no alternate form
        case (f3)
            3'h0: take = (a == b);
            3'h1: take = (a != b);
            3'h4: take = $signed(a) < $signed(b);
            3'h5: take = $signed(a) >= $signed(b);
            3'h6: take = a < b;
            default: take = a >= b;
        endcase
        mNextPc = mPc + 64'd4;
        mWrEn   = 1'b1;
        mWrVal  = '0;
        mStore  = 1'b0;
        mLoad   = 1'b0;
        mAddr   = '0;
        mData   = '0;
        case (mInstr[6:0])
            7'h33: mWrVal = alu64(f3, mInstr[30], a, b);
            7'h13: mWrVal = alu64(f3, shiftAlt, a, immI);
            7'h3b: mWrVal = aluW(f3, mInstr[30], a, b);
            7'h1b: mWrVal = aluW(f3, shiftAlt, a, immI);
            7'h37: mWrVal = immU;
            7'h17: mWrVal = mPc + immU;
            7'h6f: begin
                mWrVal  = mPc + 64'd4;
                mNextPc = mPc + immJ;
            end
            7'h67: begin
                mWrVal  = mPc + 64'd4;
                mNextPc = (a + immI) & ~64'd1;
            end
            7'h63: begin
                mWrEn = 1'b0;
                if (take) begin
                    mNextPc = mPc + immB;
                end
            end
            7'h03: begin
                mLoad  = 1'b1;
                mAddr  = a + immI;
                mWrVal = mMem[mAddr[10:3]];
            end
            7'h23: begin
                mWrEn  = 1'b0;
                mStore = 1'b1;
                mAddr  = a + immS;
                mData  = b;
            end
            default: mWrEn = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            mPc <= `RESET_PC;
            for (int i = 0; i < 32; i++) begin
                mRegs[i] <= '0;
            end
        end else begin
            mPc <= mNextPc;
            if (mWrEn && mInstr[11:7] != 5'd0) begin
                mRegs[mInstr[11:7]] <= mWrVal;
            end
            if (mStore) begin
                mMem[mAddr[10:3]] <= mData;
            end
        end
    end

    task automatic flagMismatch(input string what, input wordT got, input wordT want);
        errors++;
        $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    resetPc: assert property (@(posedge clk) $fell(reset) |-> pc == `RESET_PC)
        else flagMismatch("pc after reset", $sampled(pc), `RESET_PC);
    quietInReset: assert property (@(posedge clk) reset |-> !memWrite && !memRead)
        else flagMismatch("strobes in reset", wordT'($sampled({memRead, memWrite})), '0);
    pcMatch: assert property (@(posedge clk) disable iff (reset) pc == mPc)
        else flagMismatch("pc", $sampled(pc), $sampled(mPc));
    strobeMatch: assert property (@(posedge clk) disable iff (reset)
            {memRead, memWrite} == {mLoad, mStore})
        else flagMismatch("memRead, memWrite", wordT'($sampled({memRead, memWrite})),
                          wordT'($sampled({mLoad, mStore})));
    addrMatch: assert property (@(posedge clk) disable iff (reset)
            (mStore || mLoad) |-> dataAddr == mAddr)
        else flagMismatch("dataAddr", $sampled(dataAddr), $sampled(mAddr));
    dataMatch: assert property (@(posedge clk) disable iff (reset)
            mStore |-> dataWrite == mData)
        else flagMismatch("dataWrite", $sampled(dataWrite), $sampled(mData));

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        errors   = 0;
        cycles   = 0;
        finished = 1'b0;
        lfsr     = 32'h2f;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = nopInstr;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(i);
            mMem[i] = fillWord(i);
        end
        buildProgram();
        limit = progLen * 4 + 100;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        while (!finished && cycles < limit) begin
            @(negedge clk);
            cycles++;
            finished = (pc == haltPc);
        end
        repeat (2) @(negedge clk);  // parked jump gets checked too
        if (!finished) begin
            $display("Timeout: the program did not reach its end within %0d cycles", limit);
        end
        $display("Checks failed: %0d, timeouts: %0d", errors, finished ? 0 : 1);
        if (errors == 0 && finished) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== rvCore.f ====
+incdir+.
rvIsaPkg.sv
rvCtrlPkg.sv
ctrlIf.sv
decoder.sv
immGen.sv
regFile.sv
alu.sv
pcUnit.sv
rvCore.sv
rvCoreTb.sv

// ==== Makefile ====
all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb \
		-f rvCore.f --Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "simulation FAILED, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
